/* hdl/bs_pkg.sv */
package bs_pkg;

    // Class of the instruction offered at dispatch
    typedef enum logic [1:0] {
        CLASS_ALU    = 2'd0,
        CLASS_BRANCH = 2'd1,
        CLASS_JUMP   = 2'd2
    } inst_class_t;

    // Branch tags, one checkpoint each
    localparam int DEFAULT_NUM_TAGS = 4;

    localparam int DEFAULT_NUM_ARCH_REGS = 8;
    localparam int DEFAULT_NUM_PHYS_REGS = 16;
    localparam int DEFAULT_ADDR_WIDTH = 32;

    // Width of the ROB tail pointer carried in a checkpoint
    localparam int DEFAULT_ROB_TAIL_WIDTH = 5;

endpackage

/* hdl/branch_tag_alloc.sv */
`timescale 1ns/1ps

module branch_tag_alloc
    import bs_pkg::*;
#(
    parameter int NUM_TAGS = DEFAULT_NUM_TAGS
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                dispatch_valid,
    input  inst_class_t         dispatch_class,
    input  logic                restore_valid,
    input  logic [NUM_TAGS-1:0] release_mask,
    output logic [NUM_TAGS-1:0] alloc_tag,
    output logic [NUM_TAGS-1:0] live_mask,
    output logic                tag_full,
    output logic                tag_grant
);

    logic is_ctrl;

    assign is_ctrl = (dispatch_class == CLASS_BRANCH) || (dispatch_class == CLASS_JUMP);

    // Lowest clear bit of the live register, zero when every tag is taken
    assign alloc_tag = ~live_mask & (live_mask + 1'b1);
    assign tag_full = &live_mask;

    // Wrong-path dispatches during a restore never get a tag
    assign tag_grant = dispatch_valid && is_ctrl && !tag_full && !restore_valid;

    always_ff @(posedge clock) begin
        if (reset) begin
            live_mask <= '0;
        end else begin
            // Release wins over a grant to the same bit
            live_mask <= (live_mask | (tag_grant ? alloc_tag : '0)) & ~release_mask;
        end
    end

endmodule

/* hdl/checkpoint_stack.sv */
`timescale 1ns/1ps

module checkpoint_stack
    import bs_pkg::*;
#(
    parameter int NUM_TAGS = DEFAULT_NUM_TAGS,
    parameter int NUM_ARCH_REGS = DEFAULT_NUM_ARCH_REGS,
    parameter int NUM_PHYS_REGS = DEFAULT_NUM_PHYS_REGS,
    parameter int ADDR_WIDTH = DEFAULT_ADDR_WIDTH,
    parameter int ROB_TAIL_WIDTH = DEFAULT_ROB_TAIL_WIDTH,
    localparam int TAG_IDX_W = (NUM_TAGS > 1) ? $clog2(NUM_TAGS) : 1,
    localparam int PHYS_IDX_W = $clog2(NUM_PHYS_REGS),
    localparam int MAP_W = NUM_ARCH_REGS * PHYS_IDX_W
) (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      tag_grant,
    input  logic [NUM_TAGS-1:0]       alloc_tag,
    input  logic [NUM_TAGS-1:0]       live_mask,
    input  inst_class_t               dispatch_class,
    input  logic [ADDR_WIDTH-1:0]     dispatch_pc,
    input  logic [ADDR_WIDTH-1:0]     dispatch_recovery_pc,
    input  logic [ROB_TAIL_WIDTH-1:0] dispatch_rob_tail,
    input  logic [MAP_W-1:0]          map_flat,
    input  logic [NUM_PHYS_REGS-1:0]  free_vec,
    input  logic                      retire_valid,
    input  logic [PHYS_IDX_W-1:0]     retire_phys_free,
    input  logic                      complete_valid,
    input  logic [NUM_TAGS-1:0]       complete_tag,
    input  logic                      complete_mispredict,
    input  logic [ADDR_WIDTH-1:0]     complete_target_pc,
    output logic [NUM_TAGS-1:0]       release_mask,
    output logic                      resolve_valid,
    output logic                      resolve_is_branch,
    output logic [ADDR_WIDTH-1:0]     resolve_branch_pc,
    output logic                      restore_valid,
    output logic [ADDR_WIDTH-1:0]     pc_restore,
    output logic [ROB_TAIL_WIDTH-1:0] rob_tail_restore,
    output logic [MAP_W-1:0]          map_restore_flat,
    output logic [NUM_PHYS_REGS-1:0]  free_restore
);

    // One checkpoint per tag
    inst_class_t               ck_class    [NUM_TAGS];
    logic [ADDR_WIDTH-1:0]     ck_pc       [NUM_TAGS];
    logic [ADDR_WIDTH-1:0]     ck_rec_pc   [NUM_TAGS];
    logic [ROB_TAIL_WIDTH-1:0] ck_rob_tail [NUM_TAGS];
    logic [MAP_W-1:0]          ck_map      [NUM_TAGS];
    logic [NUM_PHYS_REGS-1:0]  ck_free     [NUM_TAGS];
    logic [NUM_TAGS-1:0]       ck_dep      [NUM_TAGS];

    logic [TAG_IDX_W-1:0]     sel;
    logic                     hit;
    logic [NUM_PHYS_REGS-1:0] retire_bit;

    assign retire_bit = retire_valid ? (NUM_PHYS_REGS'(1) << retire_phys_free) : '0;

    // Index of the completing one-hot tag
    always_comb begin
        sel = '0;
        for (int i = 0; i < NUM_TAGS; i++) begin
            if (complete_tag[i]) begin
                sel = TAG_IDX_W'(i);
            end
        end
    end

    assign hit = complete_valid && |(complete_tag & live_mask);

    assign resolve_valid = hit;
    assign resolve_is_branch = hit && (ck_class[sel] == CLASS_BRANCH);
    assign resolve_branch_pc = ck_pc[sel];
    assign restore_valid = hit && complete_mispredict;

    // A jump's real target only becomes known at completion
    assign pc_restore = (ck_class[sel] == CLASS_BRANCH) ? ck_rec_pc[sel] : complete_target_pc;
    assign rob_tail_restore = ck_rob_tail[sel];
    assign map_restore_flat = ck_map[sel];
    assign free_restore = ck_free[sel];

    // A mispredict also kills every live branch younger than the resolving one
    always_comb begin
        release_mask = '0;
        if (hit) begin
            release_mask = complete_tag;
            if (complete_mispredict) begin
                for (int i = 0; i < NUM_TAGS; i++) begin
                    if (live_mask[i] && |(ck_dep[i] & complete_tag)) begin
                        release_mask[i] = 1'b1;
                    end
                end
            end
        end
    end

    // Dependency masks lose resolved tags so a reused tag is not mistaken for an old one
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < NUM_TAGS; i++) begin
                ck_dep[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_TAGS; i++) begin
                if (tag_grant && alloc_tag[i]) begin
                    ck_dep[i] <= live_mask & ~release_mask;
                end else begin
                    ck_dep[i] <= ck_dep[i] & ~release_mask;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < NUM_TAGS; i++) begin
            if (tag_grant && alloc_tag[i]) begin
                ck_class[i] <= dispatch_class;
                ck_pc[i] <= dispatch_pc;
                ck_rec_pc[i] <= dispatch_recovery_pc;
                ck_rob_tail[i] <= dispatch_rob_tail;
                // Branch has no destination, so the pre-edge map is the right snapshot
                ck_map[i] <= map_flat;
                ck_free[i] <= free_vec | retire_bit;
            end else if (live_mask[i]) begin
                // Registers retired after the snapshot must stay free after a restore
                ck_free[i] <= ck_free[i] | retire_bit;
            end
        end
    end

endmodule

/* hdl/rename_map.sv */
`timescale 1ns/1ps

module rename_map
    import bs_pkg::*;
#(
    parameter int NUM_ARCH_REGS = DEFAULT_NUM_ARCH_REGS,
    parameter int NUM_PHYS_REGS = DEFAULT_NUM_PHYS_REGS,
    localparam int ARCH_IDX_W = $clog2(NUM_ARCH_REGS),
    localparam int PHYS_IDX_W = $clog2(NUM_PHYS_REGS),
    localparam int MAP_W = NUM_ARCH_REGS * PHYS_IDX_W
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  dispatch_valid,
    input  logic                  dispatch_has_dest,
    input  logic [ARCH_IDX_W-1:0] dispatch_dest_arch,
    input  logic [ARCH_IDX_W-1:0] dispatch_src_arch,
    input  logic [PHYS_IDX_W-1:0] alloc_phys,
    input  logic                  alloc_ok,
    input  logic                  restore_valid,
    input  logic [MAP_W-1:0]      map_restore_flat,
    output logic [PHYS_IDX_W-1:0] src_phys,
    output logic [MAP_W-1:0]      map_flat
);

    logic [PHYS_IDX_W-1:0] map_table [NUM_ARCH_REGS];

    // Source sees the table before this cycle's destination write
    assign src_phys = map_table[dispatch_src_arch];

    always_comb begin
        for (int i = 0; i < NUM_ARCH_REGS; i++) begin
            map_flat[i*PHYS_IDX_W +: PHYS_IDX_W] = map_table[i];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // Identity mapping out of reset
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                map_table[i] <= PHYS_IDX_W'(i);
            end
        end else if (restore_valid) begin
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                map_table[i] <= map_restore_flat[i*PHYS_IDX_W +: PHYS_IDX_W];
            end
        end else if (dispatch_valid && dispatch_has_dest && alloc_ok) begin
            map_table[dispatch_dest_arch] <= alloc_phys;
        end
    end

endmodule

/* hdl/free_list.sv */
`timescale 1ns/1ps

module free_list
    import bs_pkg::*;
#(
    parameter int NUM_ARCH_REGS = DEFAULT_NUM_ARCH_REGS,
    parameter int NUM_PHYS_REGS = DEFAULT_NUM_PHYS_REGS,
    localparam int PHYS_IDX_W = $clog2(NUM_PHYS_REGS)
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     dispatch_valid,
    input  logic                     dispatch_has_dest,
    input  logic                     restore_valid,
    input  logic                     retire_valid,
    input  logic [PHYS_IDX_W-1:0]    retire_phys_free,
    input  logic [NUM_PHYS_REGS-1:0] free_restore,
    output logic [PHYS_IDX_W-1:0]    alloc_phys,
    output logic                     alloc_ok,
    output logic                     list_empty,
    output logic [NUM_PHYS_REGS-1:0] free_vec
);

    logic [NUM_PHYS_REGS-1:0] alloc_bit;
    logic [NUM_PHYS_REGS-1:0] retire_bit;

    assign list_empty = ~|free_vec;

    // Isolate the lowest set bit
    assign alloc_bit = free_vec & ~(free_vec - 1'b1);

    always_comb begin
        alloc_phys = '0;
        for (int i = 0; i < NUM_PHYS_REGS; i++) begin
            if (alloc_bit[i]) begin
                alloc_phys = PHYS_IDX_W'(i);
            end
        end
    end

    assign alloc_ok = dispatch_valid && dispatch_has_dest && !list_empty && !restore_valid;
    assign retire_bit = retire_valid ? (NUM_PHYS_REGS'(1) << retire_phys_free) : '0;

    always_ff @(posedge clock) begin
        if (reset) begin
            // Registers below NUM_ARCH_REGS hold the identity mapping
            free_vec <= ~((NUM_PHYS_REGS'(1) << NUM_ARCH_REGS) - 1'b1);
        end else if (restore_valid) begin
            free_vec <= free_restore | retire_bit;
        end else begin
            free_vec <= (free_vec & ~(alloc_ok ? alloc_bit : '0)) | retire_bit;
        end
    end

endmodule

/* hdl/branch_recovery_top.sv */
`timescale 1ns/1ps

module branch_recovery_top
    import bs_pkg::*;
#(
    parameter int NUM_TAGS = DEFAULT_NUM_TAGS,
    parameter int NUM_ARCH_REGS = DEFAULT_NUM_ARCH_REGS,
    parameter int NUM_PHYS_REGS = DEFAULT_NUM_PHYS_REGS,
    parameter int ADDR_WIDTH = DEFAULT_ADDR_WIDTH,
    parameter int ROB_TAIL_WIDTH = DEFAULT_ROB_TAIL_WIDTH,
    localparam int ARCH_IDX_W = $clog2(NUM_ARCH_REGS),
    localparam int PHYS_IDX_W = $clog2(NUM_PHYS_REGS),
    localparam int MAP_W = NUM_ARCH_REGS * PHYS_IDX_W
) (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      dispatch_valid,
    input  inst_class_t               dispatch_class,
    input  logic [ADDR_WIDTH-1:0]     dispatch_pc,
    input  logic [ADDR_WIDTH-1:0]     dispatch_recovery_pc,
    input  logic                      dispatch_has_dest,
    input  logic [ARCH_IDX_W-1:0]     dispatch_dest_arch,
    input  logic [ARCH_IDX_W-1:0]     dispatch_src_arch,
    input  logic [ROB_TAIL_WIDTH-1:0] dispatch_rob_tail,
    output logic                      dispatch_stall,
    output logic [PHYS_IDX_W-1:0]     dispatch_phys_dest,
    output logic [PHYS_IDX_W-1:0]     dispatch_src_phys,
    output logic [NUM_TAGS-1:0]       dispatch_b_mask,
    output logic [NUM_TAGS-1:0]       dispatch_b_tag,
    input  logic                      complete_valid,
    input  logic [NUM_TAGS-1:0]       complete_tag,
    input  logic                      complete_mispredict,
    input  logic [ADDR_WIDTH-1:0]     complete_target_pc,
    output logic                      resolve_valid,
    output logic                      resolve_is_branch,
    output logic [ADDR_WIDTH-1:0]     resolve_branch_pc,
    output logic                      restore_valid,
    output logic [ADDR_WIDTH-1:0]     pc_restore,
    output logic [ROB_TAIL_WIDTH-1:0] rob_tail_restore,
    input  logic                      retire_valid,
    input  logic [PHYS_IDX_W-1:0]     retire_phys_free
);

    logic                     is_ctrl;
    logic                     dispatch_go;
    logic                     tag_full;
    logic                     tag_grant;
    logic [NUM_TAGS-1:0]      release_mask;
    logic [MAP_W-1:0]         map_flat;
    logic [MAP_W-1:0]         map_restore_flat;
    logic [NUM_PHYS_REGS-1:0] free_vec;
    logic [NUM_PHYS_REGS-1:0] free_restore;
    logic                     alloc_ok;
    logic                     list_empty;

    assign is_ctrl = (dispatch_class == CLASS_BRANCH) || (dispatch_class == CLASS_JUMP);
    assign dispatch_stall = (is_ctrl && tag_full) || (dispatch_has_dest && list_empty);

    // Blocks see only dispatches that are not stalled, restore is checked inside
    assign dispatch_go = dispatch_valid && !dispatch_stall;

    branch_tag_alloc #(
        .NUM_TAGS (NUM_TAGS)
    ) u_tag_alloc (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_go),
        .dispatch_class (dispatch_class),
        .restore_valid  (restore_valid),
        .release_mask   (release_mask),
        .alloc_tag      (dispatch_b_tag),
        .live_mask      (dispatch_b_mask),
        .tag_full       (tag_full),
        .tag_grant      (tag_grant)
    );

    checkpoint_stack #(
        .NUM_TAGS       (NUM_TAGS),
        .NUM_ARCH_REGS  (NUM_ARCH_REGS),
        .NUM_PHYS_REGS  (NUM_PHYS_REGS),
        .ADDR_WIDTH     (ADDR_WIDTH),
        .ROB_TAIL_WIDTH (ROB_TAIL_WIDTH)
    ) u_checkpoint (
        .clock                (clock),
        .reset                (reset),
        .tag_grant            (tag_grant),
        .alloc_tag            (dispatch_b_tag),
        .live_mask            (dispatch_b_mask),
        .dispatch_class       (dispatch_class),
        .dispatch_pc          (dispatch_pc),
        .dispatch_recovery_pc (dispatch_recovery_pc),
        .dispatch_rob_tail    (dispatch_rob_tail),
        .map_flat             (map_flat),
        .free_vec             (free_vec),
        .retire_valid         (retire_valid),
        .retire_phys_free     (retire_phys_free),
        .complete_valid       (complete_valid),
        .complete_tag         (complete_tag),
        .complete_mispredict  (complete_mispredict),
        .complete_target_pc   (complete_target_pc),
        .release_mask         (release_mask),
        .resolve_valid        (resolve_valid),
        .resolve_is_branch    (resolve_is_branch),
        .resolve_branch_pc    (resolve_branch_pc),
        .restore_valid        (restore_valid),
        .pc_restore           (pc_restore),
        .rob_tail_restore     (rob_tail_restore),
        .map_restore_flat     (map_restore_flat),
        .free_restore         (free_restore)
    );

    rename_map #(
        .NUM_ARCH_REGS (NUM_ARCH_REGS),
        .NUM_PHYS_REGS (NUM_PHYS_REGS)
    ) u_rename_map (
        .clock              (clock),
        .reset              (reset),
        .dispatch_valid     (dispatch_go),
        .dispatch_has_dest  (dispatch_has_dest),
        .dispatch_dest_arch (dispatch_dest_arch),
        .dispatch_src_arch  (dispatch_src_arch),
        .alloc_phys         (dispatch_phys_dest),
        .alloc_ok           (alloc_ok),
        .restore_valid      (restore_valid),
        .map_restore_flat   (map_restore_flat),
        .src_phys           (dispatch_src_phys),
        .map_flat           (map_flat)
    );

    free_list #(
        .NUM_ARCH_REGS (NUM_ARCH_REGS),
        .NUM_PHYS_REGS (NUM_PHYS_REGS)
    ) u_free_list (
        .clock             (clock),
        .reset             (reset),
        .dispatch_valid    (dispatch_go),
        .dispatch_has_dest (dispatch_has_dest),
        .restore_valid     (restore_valid),
        .retire_valid      (retire_valid),
        .retire_phys_free  (retire_phys_free),
        .free_restore      (free_restore),
        .alloc_phys        (dispatch_phys_dest),
        .alloc_ok          (alloc_ok),
        .list_empty        (list_empty),
        .free_vec          (free_vec)
    );

endmodule

/* tb/tb_branch_recovery.sv */
`timescale 1ns/1ps

module tb_branch_recovery
    import bs_pkg::*;
();

    // Step kinds used when building the table
    localparam int ALU = 0, LOOK = 1, CTRL = 2, DONE = 3, RETIRE = 4;

    typedef struct packed {
        logic [2:0]  test;
        logic        dv, hd, cv, cmis, rv;
        logic [1:0]  cls;
        logic [2:0]  dest, src;
        logic [3:0]  ctag, rphys;
        logic [4:0]  tail;
        logic [31:0] pc, rpc, ctpc;
        // Expected outputs, filled in by the reference model
        logic        e_stall, e_rsv, e_rsb, e_rst;
        logic [3:0]  e_pdest, e_src, e_btag, e_bmask;
        logic [31:0] e_rspc, e_pcr;
        logic [4:0]  e_tail;
    } step_t;

    logic        clock = 1'b0;
    logic        reset = 1'b1;
    logic        dispatch_valid, dispatch_has_dest, complete_valid, complete_mispredict;
    logic        retire_valid, dispatch_stall, resolve_valid, resolve_is_branch, restore_valid;
    inst_class_t dispatch_class;
    logic [2:0]  dispatch_dest_arch, dispatch_src_arch;
    logic [3:0]  complete_tag, retire_phys_free, dispatch_phys_dest, dispatch_src_phys;
    logic [3:0]  dispatch_b_mask, dispatch_b_tag;
    logic [4:0]  dispatch_rob_tail, rob_tail_restore;
    logic [31:0] dispatch_pc, dispatch_recovery_pc, complete_target_pc;
    logic [31:0] resolve_branch_pc, pc_restore;

    step_t steps [64];
    int    num_steps = 0;
    int    errors = 0;
    int    test_errors = 0;
    int    tests_failed = 0;
    int    wait_cycles = 0;
    string test_name [5] = '{
        "reset state", "alu rename", "tag allocation", "branch mispredict",
        "nested squash and jump"
    };

    // Reference model of the map, free list, live tags and checkpoints
    logic [7:0][3:0] m_map;
    logic [15:0]     m_free;
    logic [3:0]      m_live;
    logic [7:0][3:0] c_map [4];
    logic [15:0]     c_free [4];
    logic [3:0]      c_dep [4];
    step_t           c_step [4];

    branch_recovery_top u_dut (.*);

    always #20 clock = ~clock;

    task automatic add_step(input int t, input int kind, input int a, input int b,
                            input logic [31:0] c, input logic [31:0] d);
        step_t s;
        s = '0;
        s.test = 3'(t);
        case (kind)
            ALU: begin
                s.dv = 1'b1;
                s.hd = 1'b1;
                s.dest = 3'(a);
                s.src = 3'(b);
            end
            LOOK: s.src = 3'(a);
            CTRL: begin
                s.dv = 1'b1;
                s.cls = 2'(a);
                s.tail = 5'(b);
                s.pc = c;
                s.rpc = d;
            end
            DONE: begin
                s.cv = 1'b1;
                s.ctag = 4'(a);
                s.cmis = b[0];
                s.ctpc = c;
            end
            default: begin
                s.rv = 1'b1;
                s.rphys = 4'(a);
            end
        endcase
        steps[num_steps] = s;
        num_steps++;
    endtask

    task automatic build_table();
        add_step(0, LOOK, 3, 0, 0, 0);
        add_step(0, LOOK, 6, 0, 0, 0);
        // Renames take p8, p9, p10, then the retired p1
        add_step(1, ALU, 1, 0, 0, 0);
        add_step(1, ALU, 2, 1, 0, 0);
        add_step(1, ALU, 3, 2, 0, 0);
        add_step(1, LOOK, 3, 0, 0, 0);
        add_step(1, RETIRE, 1, 0, 0, 0);
        add_step(1, ALU, 4, 3, 0, 0);
        // Four branches fill the tags, the fifth stalls until 0010 resolves
        for (int i = 0; i < 5; i++) begin
            add_step(2, CTRL, CLASS_BRANCH, i, 32'h100 + 4 * i, 32'h180 + 4 * i);
        end
        add_step(2, DONE, 4'b0010, 0, 0, 0);
        add_step(2, CTRL, CLASS_BRANCH, 5, 32'h114, 32'h194);
        for (int i = 0; i < 4; i++) begin
            add_step(2, DONE, 1 << i, 0, 0, 0);
        end
        // Renames on both sides of the checkpoint, p2 retires while it is live
        add_step(3, ALU, 5, 0, 0, 0);
        add_step(3, CTRL, CLASS_BRANCH, 7, 32'h200, 32'h280);
        add_step(3, ALU, 5, 0, 0, 0);
        add_step(3, ALU, 6, 5, 0, 0);
        add_step(3, RETIRE, 2, 0, 0, 0);
        add_step(3, DONE, 4'b0001, 1, 0, 0);
        add_step(3, LOOK, 5, 0, 0, 0);
        add_step(3, LOOK, 6, 0, 0, 0);
        add_step(3, ALU, 7, 0, 0, 0);
        // Jump mispredict first, then the oldest branch squashes all younger ones
        add_step(4, CTRL, CLASS_BRANCH, 9, 32'h300, 32'h380);
        add_step(4, CTRL, CLASS_BRANCH, 10, 32'h304, 32'h384);
        add_step(4, CTRL, CLASS_JUMP, 11, 32'h308, 0);
        add_step(4, DONE, 4'b0100, 1, 32'h999, 0);
        add_step(4, CTRL, CLASS_BRANCH, 12, 32'h30c, 32'h38c);
        add_step(4, CTRL, CLASS_BRANCH, 13, 32'h310, 32'h390);
        add_step(4, DONE, 4'b0001, 1, 0, 0);
        for (int i = 0; i < 4; i++) begin
            add_step(4, CTRL, CLASS_BRANCH, 14 + i, 32'h400 + 4 * i, 32'h480 + 4 * i);
        end
        add_step(4, LOOK, 0, 0, 0, 0);
    endtask

    task automatic predict(input int k);
        step_t       s;
        logic        is_ctrl;
        logic        take;
        logic [3:0]  rel;
        logic [15:0] rbit;
        int          t;
        int          n;
        int          p;
        s = steps[k];
        t = 0;
        n = 0;
        p = 0;
        is_ctrl = (s.cls == CLASS_BRANCH) || (s.cls == CLASS_JUMP);
        s.e_stall = (is_ctrl && m_live == 4'hf) || (s.hd && m_free == 16'h0);
        s.e_src = m_map[s.src];
        s.e_bmask = m_live;
        for (int i = 3; i >= 0; i--) begin
            if (s.ctag[i]) t = i;
            if (!m_live[i]) begin
                s.e_btag = 4'b0001 << i;
                n = i;
            end
        end
        for (int i = 15; i >= 0; i--) begin
            if (m_free[i]) p = i;
        end
        s.e_pdest = 4'(p);
        s.e_rsv = s.cv && ((s.ctag & m_live) != 4'h0);
        s.e_rsb = s.e_rsv && (c_step[t].cls == CLASS_BRANCH);
        s.e_rspc = c_step[t].pc;
        s.e_rst = s.e_rsv && s.cmis;
        // Branch goes back to the path not taken, jump to its resolved target
        s.e_pcr = (c_step[t].cls == CLASS_BRANCH) ? c_step[t].rpc : s.ctpc;
        s.e_tail = c_step[t].tail;
        rel = s.e_rsv ? s.ctag : 4'h0;
        for (int i = 0; i < 4; i++) begin
            if (s.e_rst && m_live[i] && c_dep[i][t]) rel[i] = 1'b1;
        end
        rbit = s.rv ? (16'd1 << s.rphys) : 16'd0;
        take = s.dv && !s.e_stall && !s.e_rst;
        steps[k] = s;
        // State after the clock edge
        for (int i = 0; i < 4; i++) begin
            c_dep[i] = c_dep[i] & ~rel;
            if (m_live[i]) c_free[i] = c_free[i] | rbit;
        end
        if (s.e_rst) begin
            m_map = c_map[t];
            m_free = c_free[t];
        end
        if (take && is_ctrl) begin
            c_map[n] = m_map;
            c_free[n] = m_free | rbit;
            c_dep[n] = m_live & ~rel;
            c_step[n] = s;
            m_live[n] = 1'b1;
        end
        if (take && s.hd) begin
            m_map[s.dest] = 4'(p);
            m_free[p] = 1'b0;
        end
        m_free = m_free | rbit;
        m_live = m_live & ~rel;
    endtask

    task automatic drive_step(input step_t s);
        dispatch_valid <= s.dv;
        dispatch_class <= inst_class_t'(s.cls);
        dispatch_pc <= s.pc;
        dispatch_recovery_pc <= s.rpc;
        dispatch_has_dest <= s.hd;
        dispatch_dest_arch <= s.dest;
        dispatch_src_arch <= s.src;
        dispatch_rob_tail <= s.tail;
        complete_valid <= s.cv;
        complete_tag <= s.ctag;
        complete_mispredict <= s.cmis;
        complete_target_pc <= s.ctpc;
        retire_valid <= s.rv;
        retire_phys_free <= s.rphys;
    endtask

    task automatic check(input int k, input string what, input logic [31:0] got,
                         input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0d ns: step %0d %s is 0x%0h, expected 0x%0h",
                     $time, k, what, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_step(input int k, input step_t s);
        check(k, "dispatch_stall", dispatch_stall, s.e_stall);
        check(k, "dispatch_src_phys", dispatch_src_phys, s.e_src);
        check(k, "dispatch_b_mask", dispatch_b_mask, s.e_bmask);
        check(k, "resolve_valid", resolve_valid, s.e_rsv);
        check(k, "restore_valid", restore_valid, s.e_rst);
        if (s.hd && !s.e_stall) check(k, "dispatch_phys_dest", dispatch_phys_dest, s.e_pdest);
        if (s.e_btag != 4'h0) check(k, "dispatch_b_tag", dispatch_b_tag, s.e_btag);
        if (s.e_rsv) begin
            check(k, "resolve_is_branch", resolve_is_branch, s.e_rsb);
            check(k, "resolve_branch_pc", resolve_branch_pc, s.e_rspc);
        end
        if (s.e_rst) begin
            check(k, "pc_restore", pc_restore, s.e_pcr);
            check(k, "rob_tail_restore", rob_tail_restore, s.e_tail);
        end
    endtask

    initial begin
        for (int i = 0; i < 8; i++) begin
            m_map[i] = 4'(i);
        end
        m_free = 16'hff00;
        m_live = 4'h0;
        for (int i = 0; i < 4; i++) begin
            c_map[i] = '0;
            c_free[i] = '0;
            c_dep[i] = '0;
            c_step[i] = '0;
        end
        build_table();
        for (int k = 0; k < num_steps; k++) begin
            predict(k);
        end
        drive_step('0);
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        // Nothing may be pending once reset is gone
        while ((dispatch_stall !== 1'b0 || restore_valid !== 1'b0) && wait_cycles < 10) begin
            @(negedge clock);
            wait_cycles++;
        end
        if (wait_cycles >= 10) begin
            $display("Timeout: DUT outputs did not settle within 10 cycles after reset");
            errors++;
        end else begin
            for (int k = 0; k < num_steps; k++) begin
                @(posedge clock);
                drive_step(steps[k]);
                @(negedge clock);
                check_step(k, steps[k]);
                if (k == num_steps - 1 || steps[k + 1].test != steps[k].test) begin
                    $display("Test %0d (%s): %s", steps[k].test, test_name[steps[k].test],
                             (test_errors == 0) ? "ok" : "errors");
                    if (test_errors != 0) tests_failed++;
                    test_errors = 0;
                end
            end
        end
        $display("Summary: 5 tests, %0d with errors, %0d failed checks", tests_failed, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
hdl/bs_pkg.sv
hdl/branch_tag_alloc.sv
hdl/checkpoint_stack.sv
hdl/rename_map.sv
hdl/free_list.sv
hdl/branch_recovery_top.sv
tb/tb_branch_recovery.sv
